// ==== dv/tb_int_core.sv ====
`default_nettype none

`include "rv_defines.svh"

module tb_int_core;
    import rv_pkg::*;

    localparam logic [6:0] BASE = 7'h00;            // funct7 for add, srl.
    localparam logic [6:0] ALT  = 7'h20;            // funct7 for sub, sra.

    logic                clk;
    logic                reset;
    logic [31:0]         instr_i;
    logic                instr_valid_i;
    logic                illegal_o;
    logic                wb_valid_o;
    logic [4:0]          wb_rd_o;
    logic [`RV_XLEN-1:0] wb_data_o;

    logic [`RV_XLEN-1:0] rf [`RV_NREGS];            // reference register model.
    string               t_name [$];                // stimulus table.
    instr_u              t_instr [$];
    logic                t_ill [$];
    string               exp_name_q [$];            // pending writebacks.
    logic [4:0]          exp_rd_q [$];
    logic [`RV_XLEN-1:0] exp_data_q [$];
    int                  exp_cyc_q [$];
    int                  cyc = 0;
    int                  err_cnt = 0;
    int                  n_checks = 0;
    integer              seed = 32'he6e6;

    int_core i_dut (
        .clk           (clk),
        .reset         (reset),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .illegal_o     (illegal_o),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;           // cycle stamp for wb timing.

    // ##################################################
    // instruction builders and reference model
    // ##################################################

    function automatic instr_u r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
        instr_u w;
        w.r_type = '{f7, rs2, rs1, f3, rd, OPC_OP};
        return w;
    endfunction

    function automatic instr_u i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
        instr_u w;
        w.i_type = '{imm, rs1, f3, rd, opc};
        return w;
    endfunction

    function automatic instr_u u_word(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
        instr_u w;
        w.u_type = '{imm, rd, opc};
        return w;
    endfunction

    // isa semantics straight from the spec, rf[0] is never written.
    function automatic logic [`RV_XLEN-1:0] ref_result(input instr_u ins);
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic                alt;
        a   = rf[ins.r_type.rs1];
        alt = ins.r_type.funct7[5];
        if (ins.r_type.opcode == OPC_LUI) begin
            return {ins.u_type.imm20, {(`RV_XLEN-20){1'b0}}};
        end
        if (ins.r_type.opcode == OPC_OP) begin
            b = rf[ins.r_type.rs2];
        end else begin
            b = {{(`RV_XLEN-12){ins.i_type.imm12[11]}}, ins.i_type.imm12};
        end
        case (ins.r_type.funct3)
            3'b000:  return (alt && ins.r_type.opcode == OPC_OP) ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            3'b011:  return {{(`RV_XLEN-1){1'b0}}, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];           // sign fill.
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // ##################################################
    // compare tasks
    // ##################################################

    task automatic check_wb(input string name,
                            input logic [$clog2(`RV_NREGS)-1:0] exp_rd,
                            input logic [`RV_XLEN-1:0] exp_data,
                            input logic [$clog2(`RV_NREGS)-1:0] act_rd,
                            input logic [`RV_XLEN-1:0] act_data);
        n_checks++;
        if (act_rd !== exp_rd) begin
            $display("Fail %s wb_rd: expected x%0d, actual x%0d", name, exp_rd, act_rd);
            err_cnt++;
        end
        if (act_data !== exp_data) begin
            $display("Fail %s wb_data: expected %h, actual %h", name, exp_data, act_data);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp_flag, input logic act_flag);
        n_checks++;
        if (act_flag !== exp_flag) begin
            $display("Fail %s flag: expected %b, actual %b", name, exp_flag, act_flag);
            err_cnt++;
        end
    endtask

    task automatic add_entry(input string name, input instr_u ins, input logic ill);
        t_name.push_back(name);
        t_instr.push_back(ins);
        t_ill.push_back(ill);
    endtask

    // drive one word after the edge, model it, check illegal_o late in the cycle.
    task automatic issue(input string name, input instr_u ins, input logic exp_ill);
        logic [`RV_XLEN-1:0] res;
        @(posedge clk);
        #1;
        instr_i       = ins;
        instr_valid_i = 1'b1;
        if (!exp_ill) begin
            res = ref_result(ins);
            exp_name_q.push_back(name);
            exp_rd_q.push_back(ins.r_type.rd);
            exp_data_q.push_back(res);
            exp_cyc_q.push_back(cyc + 1);           // one cycle to writeback.
            if (ins.r_type.rd != 5'd0) begin
                rf[ins.r_type.rd] = res;
            end
        end
        @(negedge clk);
        check_flag(name, exp_ill, illegal_o);
    endtask

    // ##################################################
    // writeback monitor
    // ##################################################

    always @(negedge clk) begin : wb_monitor
        string nm;
        int    c;
        if (!reset && wb_valid_o) begin
            if (exp_rd_q.size() == 0) begin
                $display("writeback to x%0d in cycle %0d with none expected", wb_rd_o, cyc);
                err_cnt++;
            end else begin
                nm = exp_name_q.pop_front();
                c  = exp_cyc_q.pop_front();
                if (c != cyc) begin
                    $display("%s wrote back in cycle %0d, expected cycle %0d", nm, cyc, c);
                    err_cnt++;
                end
                check_wb(nm, exp_rd_q.pop_front(), exp_data_q.pop_front(), wb_rd_o, wb_data_o);
            end
        end else if (!reset && exp_cyc_q.size() != 0 && exp_cyc_q[0] <= cyc) begin
            $display("%s produced no writeback in cycle %0d", exp_name_q[0], exp_cyc_q[0]);
            err_cnt++;
            void'(exp_name_q.pop_front());
            void'(exp_rd_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_cyc_q.pop_front());
        end
    end

    // ##################################################
    // stimulus
    // ##################################################

    task automatic fill_table();
        logic [31:0] v;
        add_entry("add_zero", r_word(BASE, 5'd2, 5'd1, 3'b000, 5'd9), 1'b0);   // bank at reset.
        for (int r = 1; r <= 8; r++) begin
            v = $random(seed);
            v[31] = (r >= 7) ? 1'b1 : v[31];                // x7, x8 negative.
            add_entry($sformatf("lui_x%0d", r), u_word(v[31:12], r[4:0], OPC_LUI), 1'b0);
            add_entry($sformatf("addi_x%0d", r), i_word(v[11:0], r[4:0], 3'b000, r[4:0],
                      OPC_OP_IMM), 1'b0);                   // dependent on the lui.
        end
        add_entry("add",   r_word(BASE, 5'd2, 5'd1, 3'b000, 5'd10), 1'b0);
        add_entry("sub",   r_word(ALT,  5'd2, 5'd1, 3'b000, 5'd11), 1'b0);
        add_entry("sll",   r_word(BASE, 5'd3, 5'd7, 3'b001, 5'd12), 1'b0);
        add_entry("slt",   r_word(BASE, 5'd2, 5'd7, 3'b010, 5'd13), 1'b0);
        add_entry("sltu",  r_word(BASE, 5'd2, 5'd7, 3'b011, 5'd14), 1'b0);
        add_entry("xor",   r_word(BASE, 5'd8, 5'd1, 3'b100, 5'd15), 1'b0);
        add_entry("srl",   r_word(BASE, 5'd4, 5'd7, 3'b101, 5'd16), 1'b0);
        add_entry("sra",   r_word(ALT,  5'd4, 5'd7, 3'b101, 5'd17), 1'b0);
        add_entry("or",    r_word(BASE, 5'd3, 5'd2, 3'b110, 5'd18), 1'b0);
        add_entry("and",   r_word(BASE, 5'd8, 5'd2, 3'b111, 5'd19), 1'b0);
        add_entry("addi",  i_word(12'hf9c, 5'd1, 3'b000, 5'd10, OPC_OP_IMM), 1'b0);
        add_entry("slti",  i_word(12'hfff, 5'd8, 3'b010, 5'd11, OPC_OP_IMM), 1'b0);
        add_entry("sltiu", i_word(12'hfff, 5'd1, 3'b011, 5'd12, OPC_OP_IMM), 1'b0);
        add_entry("xori",  i_word(12'h5a5, 5'd7, 3'b100, 5'd13, OPC_OP_IMM), 1'b0);
        add_entry("ori",   i_word(12'h800, 5'd2, 3'b110, 5'd14, OPC_OP_IMM), 1'b0);
        add_entry("andi",  i_word(12'h0ff, 5'd8, 3'b111, 5'd15, OPC_OP_IMM), 1'b0);
        add_entry("slli",  i_word({BASE, 5'd13}, 5'd7, 3'b001, 5'd16, OPC_OP_IMM), 1'b0);
        add_entry("srli",  i_word({BASE, 5'd7}, 5'd8, 3'b101, 5'd17, OPC_OP_IMM), 1'b0);
        add_entry("srai",  i_word({ALT, 5'd7}, 5'd8, 3'b101, 5'd18, OPC_OP_IMM), 1'b0);
        add_entry("lui",   u_word(20'hdeadb, 5'd19, OPC_LUI), 1'b0);
        // chain of back-to-back dependencies, all through the bypass.
        add_entry("chain_addi", i_word(12'h005, 5'd0, 3'b000, 5'd20, OPC_OP_IMM), 1'b0);
        add_entry("chain_add",  r_word(BASE, 5'd20, 5'd20, 3'b000, 5'd21), 1'b0);
        add_entry("chain_sub",  r_word(ALT,  5'd20, 5'd21, 3'b000, 5'd22), 1'b0);
        add_entry("chain_sll",  r_word(BASE, 5'd20, 5'd22, 3'b001, 5'd23), 1'b0);
        add_entry("write_x0",   i_word(12'h007, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), 1'b0);
        add_entry("read_x0",    r_word(BASE, 5'd0, 5'd0, 3'b000, 5'd24), 1'b0);
        // undefined encodings aimed at live registers.
        add_entry("bad_opcode", u_word(20'h12345, 5'd1, 7'h7f), 1'b1);
        add_entry("bad_mul",    r_word(7'h01, 5'd2, 5'd1, 3'b000, 5'd2), 1'b1);
        add_entry("bad_sll_f7", r_word(ALT, 5'd2, 5'd1, 3'b001, 5'd3), 1'b1);
        add_entry("bad_slli",   i_word({ALT, 5'd3}, 5'd1, 3'b001, 5'd4, OPC_OP_IMM), 1'b1);
        add_entry("bad_srli",   i_word({7'h01, 5'd3}, 5'd1, 3'b101, 5'd5, OPC_OP_IMM), 1'b1);
        add_entry("bad_load",   i_word(12'h000, 5'd1, 3'b010, 5'd6, 7'h03), 1'b1);
        for (int k = 1; k < `RV_NREGS; k++) begin
            add_entry($sformatf("readback_x%0d", k),
                      r_word(BASE, 5'd0, k[4:0], 3'b110, k[4:0]), 1'b0);   // or xk, xk, x0.
        end
    endtask

    initial begin
        int wait_cnt;
        reset         = 1'b1;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        foreach (rf[i]) rf[i] = '0;
        fill_table();
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_flag("wb_idle_after_reset", 1'b0, wb_valid_o);
        for (int i = 0; i < t_name.size(); i++) begin
            issue(t_name[i], t_instr[i], t_ill[i]);
        end
        @(posedge clk);
        #1;
        instr_valid_i = 1'b0;
        wait_cnt = 0;
        while (exp_rd_q.size() != 0 && wait_cnt < 10) begin     // drain, bounded.
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_rd_q.size() != 0) begin
            $display("%0d writebacks never arrived", exp_rd_q.size());
            err_cnt++;
        end
        $display("checks: %0d, errors: %0d", n_checks, err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog on the whole run.
    initial begin
        for (int i = 0; i < 2000; i++) begin
            @(posedge clk);
        end
        $display("simulation ran past its cycle limit");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/decode_issue.sv ====
`default_nettype none

`include "rv_defines.svh"

module decode_issue (
    input  wire rv_pkg::instr_u                     instr_i,
    input  wire logic                               instr_valid_i,
    output logic      [$clog2(`RV_NREGS)-1:0]       rs1_o,
    output logic      [$clog2(`RV_NREGS)-1:0]       rs2_o,
    input  wire logic [`RV_XLEN-1:0]                rd1_i,
    input  wire logic [`RV_XLEN-1:0]                rd2_i,
    input  wire logic                               wb_en_i,
    input  wire logic [$clog2(`RV_NREGS)-1:0]       wb_rd_i,
    input  wire logic [`RV_XLEN-1:0]                wb_data_i,
    output logic                                    illegal_o,
    exec_if.issue                                   exe
);
    import rv_pkg::*;

    localparam logic [6:0] F7_BASE = 7'b0000000;    // add, srl, and the rest.
    localparam logic [6:0] F7_ALT  = 7'b0100000;    // sub and sra.

    logic                legal;             // opcode and funct known.
    alu_op_e             alu_op;
    logic                use_imm;           // op_b from immediate.
    logic                zero_a;            // lui ignores rs1.
    logic [`RV_XLEN-1:0] imm;
    logic                fwd_a;
    logic                fwd_b;
    logic [`RV_XLEN-1:0] src_a;
    logic [`RV_XLEN-1:0] src_b;

    // register fields sit at the same bits in every format.
    assign rs1_o = instr_i.r_type.rs1;
    assign rs2_o = instr_i.r_type.rs2;

    // ##################################################
    // decode
    // ##################################################

    always_comb begin
        legal   = 1'b1;
        alu_op  = ALU_ADD;
        use_imm = 1'b0;
        zero_a  = 1'b0;
        imm     = {{(`RV_XLEN-12){instr_i.i_type.imm12[11]}}, instr_i.i_type.imm12};
        case (instr_i.r_type.opcode)
            OPC_OP: begin
                case ({instr_i.r_type.funct7, instr_i.r_type.funct3})
                    {F7_BASE, 3'b000}: alu_op = ALU_ADD;
                    {F7_ALT,  3'b000}: alu_op = ALU_SUB;
                    {F7_BASE, 3'b001}: alu_op = ALU_SLL;
                    {F7_BASE, 3'b010}: alu_op = ALU_SLT;
                    {F7_BASE, 3'b011}: alu_op = ALU_SLTU;
                    {F7_BASE, 3'b100}: alu_op = ALU_XOR;
                    {F7_BASE, 3'b101}: alu_op = ALU_SRL;
                    {F7_ALT,  3'b101}: alu_op = ALU_SRA;
                    {F7_BASE, 3'b110}: alu_op = ALU_OR;
                    {F7_BASE, 3'b111}: alu_op = ALU_AND;
                    default:           legal  = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                case (instr_i.i_type.funct3)
                    3'b000: alu_op = ALU_ADD;
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLTU;
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    3'b001: begin
                        alu_op = ALU_SLL;
                        legal  = (instr_i.r_type.funct7 == F7_BASE);    // upper imm bits zero.
                    end
                    default: begin                                      // 3'b101 shifts.
                        if (instr_i.r_type.funct7 == F7_ALT) begin
                            alu_op = ALU_SRA;                           // srai.
                        end else begin
                            alu_op = ALU_SRL;
                            legal  = (instr_i.r_type.funct7 == F7_BASE);
                        end
                    end
                endcase
            end
            OPC_LUI: begin
                alu_op  = ALU_PASS_B;
                use_imm = 1'b1;
                zero_a  = 1'b1;
                imm     = {instr_i.u_type.imm20, {(`RV_XLEN-20){1'b0}}};
            end
            default: legal = 1'b0;                                      // unknown opcode.
        endcase
        exe.valid = instr_valid_i && legal;
        illegal_o = instr_valid_i && !legal;
    end

    // ##################################################
    // operand select and bypass
    // ##################################################

    // result still in execute overrides the bank, never for x0.
    assign fwd_a = wb_en_i && (wb_rd_i != '0) && (wb_rd_i == rs1_o);
    assign fwd_b = wb_en_i && (wb_rd_i != '0) && (wb_rd_i == rs2_o);
    assign src_a = fwd_a ? wb_data_i : rd1_i;
    assign src_b = fwd_b ? wb_data_i : rd2_i;

    assign exe.alu_op = alu_op;
    assign exe.op_a   = zero_a  ? '0  : src_a;
    assign exe.op_b   = use_imm ? imm : src_b;
    assign exe.rd     = instr_i.r_type.rd;

endmodule

`default_nettype wire

// ==== hdl/exec_if.sv ====
`default_nettype none

`include "rv_defines.svh"

interface exec_if;
    import rv_pkg::*;

    logic                valid;             // legal op present this cycle.
    alu_op_e             alu_op;            // decoded operation.
    logic [`RV_XLEN-1:0] op_a;              // resolved rs1 value.
    logic [`RV_XLEN-1:0] op_b;              // resolved rs2 or immediate.
    logic [4:0]          rd;                // destination register.

    // decode side drives everything.
    modport issue (
        output valid,
        output alu_op,
        output op_a,
        output op_b,
        output rd
    );

    // execute samples on the rising edge.
    modport exe (
        input valid,
        input alu_op,
        input op_a,
        input op_b,
        input rd
    );

endinterface

`default_nettype wire

// ==== hdl/execute.sv ====
`default_nettype none

`include "rv_defines.svh"

module execute (
    input  wire logic                          clk,
    input  wire logic                          reset,
    exec_if.exe                                exe,
    output logic                               wb_en_o,
    output logic      [$clog2(`RV_NREGS)-1:0]  wb_rd_o,
    output logic      [`RV_XLEN-1:0]           wb_data_o
);
    import rv_pkg::*;

    logic                          valid_q;     // stage occupied.
    alu_op_e                       op_q;
    logic [`RV_XLEN-1:0]           a_q;
    logic [`RV_XLEN-1:0]           b_q;
    logic [$clog2(`RV_NREGS)-1:0]  rd_q;
    logic [4:0]                    shamt;
    logic                          lt_s;
    logic                          lt_u;
    logic [`RV_XLEN-1:0]           result;

    // ##################################################
    // stage register
    // ##################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= exe.valid;
        end
    end

    // payload follows the bus every cycle.
    always_ff @(posedge clk) begin
        op_q <= exe.alu_op;
        a_q  <= exe.op_a;
        b_q  <= exe.op_b;
        rd_q <= exe.rd;
    end

    // ##################################################
    // alu
    // ##################################################

    assign shamt = b_q[4:0];                            // low five bits only.
    assign lt_s  = $signed(a_q) < $signed(b_q);
    assign lt_u  = a_q < b_q;

    always_comb begin
        case (op_q)
            ALU_ADD:    result = a_q + b_q;
            ALU_SUB:    result = a_q - b_q;
            ALU_SLL:    result = a_q << shamt;
            ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, lt_u};
            ALU_XOR:    result = a_q ^ b_q;
            ALU_SRL:    result = a_q >> shamt;
            ALU_SRA:    result = $unsigned($signed(a_q) >>> shamt);    // sign fill.
            ALU_OR:     result = a_q | b_q;
            ALU_AND:    result = a_q & b_q;
            ALU_PASS_B: result = b_q;                                   // lui.
            default:    result = '0;
        endcase
    end

    // same values feed the bank write and the bypass.
    assign wb_en_o   = valid_q;
    assign wb_rd_o   = rd_q;
    assign wb_data_o = result;

    a_wb_known: assert property (
        @(posedge clk) disable iff (reset)
        wb_en_o |-> !$isunknown(wb_data_o)
    ) else $error("writeback data unknown");

endmodule

`default_nettype wire

// ==== hdl/int_core.sv ====
`default_nettype none

`include "rv_defines.svh"

module int_core (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic [31:0]          instr_i,
    input  wire logic                 instr_valid_i,
    output logic                      illegal_o,
    output logic                      wb_valid_o,
    output logic      [4:0]           wb_rd_o,
    output logic      [`RV_XLEN-1:0]  wb_data_o
);
    import rv_pkg::*;

    instr_u              instr;             // raw word, typed view.
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [`RV_XLEN-1:0] rd1;
    logic [`RV_XLEN-1:0] rd2;
    logic                wb_en;             // writeback bundle from execute.
    logic [4:0]          wb_rd;
    logic [`RV_XLEN-1:0] wb_data;

    assign instr = instr_u'(instr_i);

    exec_if i_exe_if ();

    // ##################################################
    // stages
    // ##################################################

    decode_issue i_decode (
        .instr_i       (instr),
        .instr_valid_i (instr_valid_i),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .rd1_i         (rd1),
        .rd2_i         (rd2),
        .wb_en_i       (wb_en),             // bypass source.
        .wb_rd_i       (wb_rd),
        .wb_data_i     (wb_data),
        .illegal_o     (illegal_o),
        .exe           (i_exe_if.issue)
    );

    regbank i_regbank (
        .clk       (clk),
        .reset     (reset),
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .wr_en_i   (wb_en),                 // commits at end of wb cycle.
        .wr_addr_i (wb_rd),
        .wr_data_i (wb_data),
        .rd1_o     (rd1),
        .rd2_o     (rd2)
    );

    execute i_execute (
        .clk       (clk),
        .reset     (reset),
        .exe       (i_exe_if.exe),
        .wb_en_o   (wb_en),
        .wb_rd_o   (wb_rd),
        .wb_data_o (wb_data)
    );

    assign wb_valid_o = wb_en;
    assign wb_rd_o    = wb_rd;
    assign wb_data_o  = wb_data;

endmodule

`default_nettype wire

// ==== hdl/regbank.sv ====
`default_nettype none

`include "rv_defines.svh"

module regbank (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic [$clog2(`RV_NREGS)-1:0]  rs1_i,
    input  wire logic [$clog2(`RV_NREGS)-1:0]  rs2_i,
    input  wire logic                          wr_en_i,
    input  wire logic [$clog2(`RV_NREGS)-1:0]  wr_addr_i,
    input  wire logic [`RV_XLEN-1:0]           wr_data_i,
    output logic      [`RV_XLEN-1:0]           rd1_o,
    output logic      [`RV_XLEN-1:0]           rd2_o
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];      // entry 0 stays at reset value.

    // ##################################################
    // write port
    // ##################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;                  // whole bank cleared.
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;       // x0 writes dropped.
        end
    end

    // ##################################################
    // read ports
    // ##################################################

    // x0 comes out of storage, held at zero by the write guard.
    assign rd1_o = regs[rs1_i];
    assign rd2_o = regs[rs2_i];

    // x0 reads zero on either port whenever it is selected.
    a_x0_zero: assert property (
        @(posedge clk) disable iff (reset)
        ((rs1_i != '0) || (rd1_o == '0)) && ((rs2_i != '0) || (rd2_o == '0))
    ) else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// ==== hdl/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// ##################################################
// core dimensions
// ##################################################

// data path width, one rv32i word.
`define RV_XLEN 32

// architectural register count, x0 included.
`define RV_NREGS 32

`endif

// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // ##################################################
    // major opcodes
    // ##################################################

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,                // register-register alu.
        OPC_OP_IMM = 7'b0010011,                // register-immediate alu.
        OPC_LUI    = 7'b0110111                 // load upper immediate.
    } opcode_e;

    // ##################################################
    // alu operations
    // ##################################################

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,                      // signed compare.
        ALU_SLTU   = 4'd4,                      // unsigned compare.
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10                      // lui, op_b straight through.
    } alu_op_e;

    // ##################################################
    // instruction formats
    // ##################################################

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;                     // sign bit at [11].
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0] imm20;                     // goes to bits 31:12.
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    // one word, three views; opcode and rd line up in all of them.
    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
        u_type_t u_type;
    } instr_u;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the int_core testbench with verilator.
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_int_core \
    -Mdir obj_dir -o tb_int_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_int_core > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$log"; then
    exit 1
fi
exit 0

// ==== src.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/exec_if.sv
hdl/regbank.sv
hdl/decode_issue.sv
hdl/execute.sv
hdl/int_core.sv
dv/tb_int_core.sv
